//--- sim.f
common/cpuPkg.sv
core/regFile.sv
core/alu.sv
core/hazardUnit.sv
core/controlUnit.sv
core/datapath.sv
design/cpuTop.sv
test/clockGen.sv
test/cpu_properties.sv
test/cpuTb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it; the exit status is the result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f sim.f -o cpuSim
./obj_dir/cpuSim

//--- test/cpuTb.sv
`timescale 1ns/10ps
`default_nettype none

module cpuTb;

    localparam int clkPeriod = 40;
    localparam int resetCycles = 10;
    localparam int tableSize = 32;
    localparam int romWords = 64;
    localparam int ramWords = 256;

    localparam logic [1:0] kindNone = 2'd0;   // executes, no output
    localparam logic [1:0] kindWwd = 2'd1;
    localparam logic [1:0] kindStore = 2'd2;
    localparam logic [1:0] kindSkip = 2'd3;   // on a skipped path, never executes

    typedef struct packed {
        logic [15:0] instr;
        logic [1:0]  kind;
        logic [15:0] expA;  // WWD value or store address
        logic [15:0] expB;  // store data
    } rowT;

    logic        clk;
    logic        arstN;
    logic        instrRead;
    logic [15:0] instrAddr;
    logic [15:0] instrData;
    logic        dataRead;
    logic        dataWrite;
    logic [15:0] dataAddr;
    logic [15:0] dataOut;
    logic [15:0] dataIn;
    logic [15:0] outputPort;
    logic        wwdValid;
    logic [15:0] numInst;
    logic        isHalted;

    rowT         rows [tableSize];
    logic [15:0] rom [romWords];
    logic [15:0] ram [ramWords];
    logic [15:0] ramInit [ramWords];
    logic [15:0] wwdQ [$];
    logic [31:0] storeQ [$];
    int          seed;
    int          executed;

    clockGen u_clockGen (
        .clk  (clk),
        .arstN(arstN)
    );

    cpuTop u_dut (
        .clk       (clk),
        .arstN     (arstN),
        .instrRead (instrRead),
        .instrAddr (instrAddr),
        .instrData (instrData),
        .dataRead  (dataRead),
        .dataWrite (dataWrite),
        .dataAddr  (dataAddr),
        .dataOut   (dataOut),
        .dataIn    (dataIn),
        .outputPort(outputPort),
        .wwdValid  (wwdValid),
        .numInst   (numInst),
        .isHalted  (isHalted)
    );

    // both memories answer in the same cycle
    assign instrData = rom[instrAddr[5:0]];
    assign dataIn = dataRead ? ram[dataAddr[7:0]] : 16'hxxxx;  // valid only on a read

    always @(posedge clk) begin
        if (dataWrite) begin
            ram[dataAddr[7:0]] <= dataOut;
        end
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic compareValue(input logic [15:0] actual, input logic [15:0] expected,
                                input string what);
        if (actual !== expected) begin
            abortRun($sformatf("error: time %0t: %s is %h, expected %h",
                               $time, what, actual, expected));
        end
    endtask

    task automatic verifyResetState();
        compareValue(16'(dataRead), 16'h0, "dataRead in reset");
        compareValue(16'(dataWrite), 16'h0, "dataWrite in reset");
        compareValue(16'(wwdValid), 16'h0, "wwdValid in reset");
        compareValue(16'(isHalted), 16'h0, "isHalted in reset");
        compareValue(numInst, 16'h0, "numInst in reset");
        compareValue(instrAddr, 16'h0, "instrAddr in reset");
        compareValue(16'(instrRead), 16'h1, "instrRead in reset");
    endtask

    initial begin : mainSequence
        logic [15:0] twiceLoad;
        logic [15:0] haltPc;
        seed = 93913;
        executed = 0;
        for (int i = 0; i < ramWords; i++) begin
            ramInit[i] = 16'($random(seed));
            ram[i] <= ramInit[i];
        end
        twiceLoad = ramInit[25] + ramInit[25];
        rows[0] = '{16'h6112, kindNone, 16'h0, 16'h0};    // LHI r1, 0x12
        rows[1] = '{16'h55B4, kindNone, 16'h0, 16'h0};    // ORI r1, r1, 0xB4
        rows[2] = '{16'h42F9, kindNone, 16'h0, 16'h0};    // ADI r2, r0, -7
        rows[3] = '{16'hF6C0, kindNone, 16'h0, 16'h0};    // ADD r3, r1, r2
        rows[4] = '{16'hFC1C, kindWwd, 16'h12AD, 16'h0};
        rows[5] = '{16'hFDC1, kindNone, 16'h0, 16'h0};    // SUB r3, r3, r1
        rows[6] = '{16'hFD82, kindNone, 16'h0, 16'h0};    // AND r2, r3, r1
        rows[7] = '{16'h4305, kindNone, 16'h0, 16'h0};    // ADI r3, r0, 5
        rows[8] = '{16'hFB03, kindNone, 16'h0, 16'h0};    // ORR r0, r2, r3
        rows[9] = '{16'hF01C, kindWwd, 16'h12B5, 16'h0};
        rows[10] = '{16'hF41C, kindWwd, 16'h12B4, 16'h0};
        rows[11] = '{16'h8C03, kindStore, 16'h0008, 16'h12B5};  // SWD r0, 3(r3)
        rows[12] = '{16'h7D03, kindNone, 16'h0, 16'h0};   // LWD r1, 3(r3)
        rows[13] = '{16'hF780, kindNone, 16'h0, 16'h0};   // ADD r2, r1, r3 after load
        rows[14] = '{16'hF81C, kindWwd, 16'h12BA, 16'h0};
        rows[15] = '{16'h7C14, kindNone, 16'h0, 16'h0};   // LWD r0, 20(r3)
        rows[16] = '{16'hF040, kindNone, 16'h0, 16'h0};   // ADD r1, r0, r0
        rows[17] = '{16'hF41C, kindWwd, twiceLoad, 16'h0};
        rows[18] = '{16'h1F02, kindNone, 16'h0, 16'h0};   // BEQ taken
        rows[19] = '{16'hF81C, kindSkip, 16'h0, 16'h0};
        rows[20] = '{16'hFC1C, kindSkip, 16'h0, 16'h0};
        rows[21] = '{16'h0F05, kindNone, 16'h0, 16'h0};   // BNE not taken
        rows[22] = '{16'hFC1C, kindWwd, 16'h0005, 16'h0};
        rows[23] = '{16'h0B01, kindNone, 16'h0, 16'h0};   // BNE taken
        rows[24] = '{16'hF81C, kindSkip, 16'h0, 16'h0};
        rows[25] = '{16'h1B03, kindNone, 16'h0, 16'h0};   // BEQ not taken
        rows[26] = '{16'h901D, kindNone, 16'h0, 16'h0};   // JMP 29
        rows[27] = '{16'hF41C, kindSkip, 16'h0, 16'h0};
        rows[28] = '{16'hF41C, kindSkip, 16'h0, 16'h0};
        rows[29] = '{16'hF81C, kindWwd, 16'h12BA, 16'h0};
        rows[30] = '{16'hF01D, kindNone, 16'h0, 16'h0};   // HLT
        rows[31] = '{16'hFC1C, kindSkip, 16'h0, 16'h0};   // behind HLT
        for (int i = 0; i < romWords; i++) begin
            rom[i] = {4'hF, i[5:0], 6'd8};  // unused func, runs as nop
        end
        for (int i = 0; i < tableSize; i++) begin
            rom[i] = rows[i].instr;
            if (rows[i].kind == kindWwd) begin
                wwdQ.push_back(rows[i].expA);
            end
            if (rows[i].kind == kindStore) begin
                storeQ.push_back({rows[i].expA, rows[i].expB});
            end
            if (rows[i].kind != kindSkip) begin
                executed++;
            end
        end

        @(negedge clk);
        while (!arstN) begin
            verifyResetState();
            @(negedge clk);
        end
        verifyResetState();  // first cycle out of reset, PC not yet moved

        while (!isHalted) begin
            @(negedge clk);
        end
        haltPc = instrAddr;
        repeat (6) begin
            @(negedge clk);
            compareValue(16'(instrRead), 16'h0, "instrRead after HLT");
            compareValue(instrAddr, haltPc, "instrAddr after HLT");
        end
        compareValue(16'(wwdQ.size()), 16'h0, "count of missing WWD outputs");
        compareValue(16'(storeQ.size()), 16'h0, "count of missing stores");
        compareValue(numInst, 16'(executed), "numInst");
        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin : outputMonitor
        logic [31:0] expStore;
        @(posedge arstN);
        forever begin
            @(negedge clk);
            if (wwdValid) begin
                if (wwdQ.size() == 0) begin
                    abortRun("a WWD output appeared that the program never executes");
                end else begin
                    compareValue(outputPort, wwdQ.pop_front(), "outputPort");
                end
            end
            if (dataWrite) begin
                if (storeQ.size() == 0) begin
                    abortRun("a store appeared that the program never executes");
                end else begin
                    expStore = storeQ.pop_front();
                    compareValue(dataAddr, expStore[31:16], "dataAddr");
                    compareValue(dataOut, expStore[15:0], "dataOut");
                end
            end
        end
    end

    initial begin : watchdog
        #((tableSize * 8 + resetCycles) * clkPeriod);  // 8 cycles per row
        abortRun("timeout: the core did not halt in time");
    end

endmodule

`default_nettype wire

//--- test/cpu_properties.sv
`timescale 1ns/10ps
`default_nettype none

module cpuProperties (
    input logic                        clk,
    input logic                        arstN,
    input logic                        isHalted,
    input logic                        dataRead,
    input logic                        dataWrite,
    input logic                        idExValid,
    input logic [cpuPkg::wordSize-1:0] idExPc
);

    haltSticky: assert property (@(posedge clk) disable iff (!arstN) isHalted |=> isHalted)
        else $error("isHalted fell while the core was out of reset");

    memExclusive: assert property (@(posedge clk) disable iff (!arstN)
                                   !(dataRead && dataWrite))
        else $error("dataRead and dataWrite were high together");

    // a held decode instruction must not enter execute twice
    noDuplicate: assert property (@(posedge clk) disable iff (!arstN)
                                  (idExValid && $past(idExValid))
                                  |-> idExPc != $past(idExPc))
        else $error("idEx held the same instruction in two cycles in a row");

endmodule

bind datapath cpuProperties u_cpuProperties (
    .clk      (clk),
    .arstN    (arstN),
    .isHalted (isHalted),
    .dataRead (dataRead),
    .dataWrite(dataWrite),
    .idExValid(idEx.valid),
    .idExPc   (idEx.pc)
);

`default_nettype wire

//--- test/clockGen.sv
`timescale 1ns/10ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic arstN
);
    localparam int halfPeriod = 20;  // 40 ns clock
    localparam int resetCycles = 10;

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    initial begin
        arstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        arstN <= 1'b1;
    end

endmodule

`default_nettype wire

//--- design/cpuTop.sv
`timescale 1ns/10ps
`default_nettype none

module cpuTop (
    input  logic                        clk,
    input  logic                        arstN,
    output logic                        instrRead,
    output logic [cpuPkg::wordSize-1:0] instrAddr,
    input  logic [cpuPkg::wordSize-1:0] instrData,
    output logic                        dataRead,
    output logic                        dataWrite,
    output logic [cpuPkg::wordSize-1:0] dataAddr,
    output logic [cpuPkg::wordSize-1:0] dataOut,
    input  logic [cpuPkg::wordSize-1:0] dataIn,
    output logic [cpuPkg::wordSize-1:0] outputPort,
    output logic                        wwdValid,
    output logic [cpuPkg::wordSize-1:0] numInst,
    output logic                        isHalted
);
    import cpuPkg::*;

    instrU decInstr;  // word held in the decode stage
    ctrlT  decCtrl;

    controlUnit u_controlUnit (
        .instr(decInstr),
        .ctrl (decCtrl)
    );

    datapath u_datapath (
        .clk       (clk),
        .arstN     (arstN),
        .instrData (instrData),
        .ctrl      (decCtrl),
        .decInstr  (decInstr),
        .instrRead (instrRead),
        .instrAddr (instrAddr),
        .dataRead  (dataRead),
        .dataWrite (dataWrite),
        .dataAddr  (dataAddr),
        .dataOut   (dataOut),
        .dataIn    (dataIn),
        .outputPort(outputPort),
        .wwdValid  (wwdValid),
        .numInst   (numInst),
        .isHalted  (isHalted)
    );

endmodule

`default_nettype wire

//--- core/datapath.sv
`timescale 1ns/10ps
`default_nettype none

module datapath (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic [cpuPkg::wordSize-1:0] instrData,
    input  cpuPkg::ctrlT                ctrl,
    output cpuPkg::instrU               decInstr,
    output logic                        instrRead,
    output logic [cpuPkg::wordSize-1:0] instrAddr,
    output logic                        dataRead,
    output logic                        dataWrite,
    output logic [cpuPkg::wordSize-1:0] dataAddr,
    output logic [cpuPkg::wordSize-1:0] dataOut,
    input  logic [cpuPkg::wordSize-1:0] dataIn,
    output logic [cpuPkg::wordSize-1:0] outputPort,
    output logic                        wwdValid,
    output logic [cpuPkg::wordSize-1:0] numInst,
    output logic                        isHalted
);
    import cpuPkg::*;

    logic [wordSize-1:0] pc;
    logic                ifIdValid;
    logic [wordSize-1:0] ifIdPc;
    instrU               ifIdInstr;
    idExT                idEx;
    exMemT               exMem;
    memWbT               memWb;
    logic [wordSize-1:0] rfDataA;
    logic [wordSize-1:0] rfDataB;
    logic [1:0]          fwdA;
    logic [1:0]          fwdB;
    logic                stall;
    logic                flush;
    logic                decUsesRt;
    logic [wordSize-1:0] opA;
    logic [wordSize-1:0] opBReg;
    logic [wordSize-1:0] aluB;
    logic [wordSize-1:0] aluResult;
    logic                aluEqual;
    logic                takeBranch;
    logic [wordSize-1:0] redirectPc;
    logic [wordSize-1:0] memResult;
    logic                haltNow;
    logic                frozen;

    function automatic logic [wordSize-1:0] fwdMux(input logic [1:0]          sel,
                                                   input logic [wordSize-1:0] regVal,
                                                   input logic [wordSize-1:0] exVal,
                                                   input logic [wordSize-1:0] wbVal);
        case (sel)
            fwdExMem: return exVal;
            fwdMemWb: return wbVal;
            default:  return regVal;
        endcase
    endfunction

    assign haltNow = memWb.valid && memWb.ctrl.isHalt;
    assign frozen = isHalted || haltNow;  // younger work is dropped behind HLT

    assign instrAddr = pc;
    assign instrRead = !isHalted && !stall;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (!frozen) begin
            if (flush) begin
                pc <= redirectPc;
            end else if (!stall) begin
                pc <= pc + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ifIdValid <= 1'b0;
            ifIdPc <= '0;
            ifIdInstr <= '0;
        end else if (frozen || flush) begin
            ifIdValid <= 1'b0;
        end else if (!stall) begin
            ifIdValid <= 1'b1;
            ifIdPc <= pc;
            ifIdInstr <= instrData;
        end
    end

    assign decInstr = ifIdInstr;
    assign decUsesRt = !ctrl.aluSrcImm || ctrl.memWrite;  // R-format, branches, store data

    regFile u_regFile (
        .clk      (clk),
        .arstN    (arstN),
        .readA    (ifIdInstr.iFmt.rs),
        .readB    (ifIdInstr.iFmt.rt),
        .writeEn  (memWb.valid && memWb.ctrl.regWrite),
        .writeIdx (memWb.ctrl.destIdx),
        .writeData(memWb.result),
        .dataA    (rfDataA),
        .dataB    (rfDataB)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idEx <= '0;
        end else if (frozen || flush || stall) begin
            idEx <= '0;  // bubble
        end else begin
            idEx.valid <= ifIdValid;
            idEx.ctrl <= ctrl;
            idEx.rs <= ifIdInstr.iFmt.rs;
            idEx.rt <= ifIdInstr.iFmt.rt;
            idEx.pc <= ifIdPc;
            idEx.dataA <= rfDataA;
            idEx.dataB <= rfDataB;
        end
    end

    hazardUnit u_hazardUnit (
        .idEx      (idEx),
        .exMem     (exMem),
        .memWb     (memWb),
        .decRs     (ifIdInstr.iFmt.rs),
        .decRt     (ifIdInstr.iFmt.rt),
        .decUsesRt (decUsesRt),
        .takeBranch(takeBranch),
        .fwdA      (fwdA),
        .fwdB      (fwdB),
        .stall     (stall),
        .flush     (flush)
    );

    assign opA = fwdMux(fwdA, idEx.dataA, memResult, memWb.result);
    assign opBReg = fwdMux(fwdB, idEx.dataB, memResult, memWb.result);
    assign aluB = idEx.ctrl.aluSrcImm ? idEx.ctrl.imm : opBReg;

    alu u_alu (
        .opA   (opA),
        .opB   (aluB),
        .op    (idEx.ctrl.aluOp),
        .result(aluResult),
        .equal (aluEqual)
    );

    assign takeBranch = idEx.valid && (idEx.ctrl.isJump
                        || (idEx.ctrl.isBranch && aluEqual == idEx.ctrl.branchOnEqual));
    assign redirectPc = idEx.ctrl.isJump ? {idEx.pc[wordSize-1:12], idEx.ctrl.imm[11:0]}
                                         : idEx.pc + 1'b1 + idEx.ctrl.imm;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exMem <= '0;
        end else if (frozen) begin
            exMem <= '0;
        end else begin
            exMem.valid <= idEx.valid;
            exMem.ctrl <= idEx.ctrl;
            exMem.result <= aluResult;
            exMem.storeData <= opBReg;
        end
    end

    // memory answers in the same cycle
    assign dataRead = exMem.valid && exMem.ctrl.memRead && !haltNow;
    assign dataWrite = exMem.valid && exMem.ctrl.memWrite && !haltNow;
    assign dataAddr = exMem.result;
    assign dataOut = exMem.storeData;
    assign memResult = exMem.ctrl.memToReg ? dataIn : exMem.result;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memWb <= '0;
        end else if (frozen) begin
            memWb <= '0;
        end else begin
            memWb.valid <= exMem.valid;
            memWb.ctrl <= exMem.ctrl;
            memWb.result <= memResult;
        end
    end

    assign outputPort = memWb.result;
    assign wwdValid = memWb.valid && memWb.ctrl.isWwd;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            numInst <= '0;
            isHalted <= 1'b0;
        end else begin
            if (memWb.valid) begin
                numInst <= numInst + 1'b1;  // HLT counts too
            end
            if (haltNow) begin
                isHalted <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- core/controlUnit.sv
`timescale 1ns/10ps
`default_nettype none

module controlUnit (
    input  cpuPkg::instrU instr,
    output cpuPkg::ctrlT  ctrl
);
    import cpuPkg::*;

    always_comb begin
        ctrl = '0;
        ctrl.aluOp = aluAdd;
        ctrl.destIdx = instr.iFmt.rt;
        ctrl.imm = {{(wordSize-8){instr.iFmt.imm[7]}}, instr.iFmt.imm};
        case (instr.rFmt.opcode)
            opAlu: begin
                ctrl.destIdx = instr.rFmt.rd;
                case (instr.rFmt.func)
                    funcAdd: ctrl.regWrite = 1'b1;
                    funcSub: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp = aluSub;
                    end
                    funcAnd: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp = aluAnd;
                    end
                    funcOrr: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp = aluOr;
                    end
                    funcWwd: begin
                        ctrl.isWwd = 1'b1;
                        ctrl.aluSrcImm = 1'b1;  // rs + 0 carries the value out
                        ctrl.imm = '0;
                    end
                    funcHlt: begin
                        ctrl.isHalt = 1'b1;
                        ctrl.aluSrcImm = 1'b1;
                    end
                    default: ctrl.regWrite = 1'b0;  // unknown func runs as nop
                endcase
            end
            opAdi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opOri: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp = aluOr;
                ctrl.imm = {{(wordSize-8){1'b0}}, instr.iFmt.imm};  // zero extended
            end
            opLhi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp = aluLhi;
                ctrl.imm = {instr.iFmt.imm, 8'h00};
            end
            opLwd: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.memToReg = 1'b1;
            end
            opSwd: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            opBne: ctrl.isBranch = 1'b1;
            opBeq: begin
                ctrl.isBranch = 1'b1;
                ctrl.branchOnEqual = 1'b1;
            end
            opJmp: begin
                ctrl.isJump = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.imm = {{(wordSize-12){1'b0}}, instr.jFmt.target};
            end
            default: ctrl.regWrite = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- core/hazardUnit.sv
`timescale 1ns/10ps
`default_nettype none

module hazardUnit (
    input  cpuPkg::idExT  idEx,
    input  cpuPkg::exMemT exMem,
    input  cpuPkg::memWbT memWb,
    input  logic [1:0]    decRs,
    input  logic [1:0]    decRt,
    input  logic          decUsesRt,
    input  logic          takeBranch,
    output logic [1:0]    fwdA,
    output logic [1:0]    fwdB,
    output logic          stall,
    output logic          flush
);
    import cpuPkg::*;

    logic loadUse;

    // the younger latch holds the newer value, so exMem wins
    function automatic logic [1:0] pickSource(input logic [1:0] srcIdx,
                                              input exMemT      em,
                                              input memWbT      mw);
        if (em.valid && em.ctrl.regWrite && em.ctrl.destIdx == srcIdx) begin
            return fwdExMem;
        end
        if (mw.valid && mw.ctrl.regWrite && mw.ctrl.destIdx == srcIdx) begin
            return fwdMemWb;
        end
        return fwdReg;
    endfunction

    assign fwdA = pickSource(idEx.rs, exMem, memWb);
    assign fwdB = pickSource(idEx.rt, exMem, memWb);

    assign loadUse = idEx.valid && idEx.ctrl.memRead
                     && (idEx.ctrl.destIdx == decRs
                         || (decUsesRt && idEx.ctrl.destIdx == decRt));

    assign flush = takeBranch;
    assign stall = loadUse && !takeBranch;  // a flush discards the waiting instruction

endmodule

`default_nettype wire

//--- core/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  logic [cpuPkg::wordSize-1:0] opA,
    input  logic [cpuPkg::wordSize-1:0] opB,
    input  cpuPkg::aluOpT               op,
    output logic [cpuPkg::wordSize-1:0] result,
    output logic                        equal
);
    import cpuPkg::*;

    always_comb begin
        case (op)
            aluAdd:  result = opA + opB;
            aluSub:  result = opA - opB;
            aluAnd:  result = opA & opB;
            aluOr:   result = opA | opB;
            aluLhi:  result = opB;       // immediate is already in the high byte
            default: result = opA + opB;
        endcase
    end

    // branch compare on the two register operands
    assign equal = (opA == opB);

endmodule

`default_nettype wire

//--- core/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic [1:0]                  readA,
    input  logic [1:0]                  readB,
    input  logic                        writeEn,
    input  logic [1:0]                  writeIdx,
    input  logic [cpuPkg::wordSize-1:0] writeData,
    output logic [cpuPkg::wordSize-1:0] dataA,
    output logic [cpuPkg::wordSize-1:0] dataB
);
    import cpuPkg::*;

    logic [wordSize-1:0] regs [4];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeIdx] <= writeData;
        end
    end

    // write-back value bypasses to decode in the same cycle
    assign dataA = (writeEn && writeIdx == readA) ? writeData : regs[readA];
    assign dataB = (writeEn && writeIdx == readB) ? writeData : regs[readB];

endmodule

`default_nettype wire

//--- common/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int wordSize = 16;

    // opcodes live in instr[15:12]
    localparam logic [3:0] opBne = 4'd0;
    localparam logic [3:0] opBeq = 4'd1;
    localparam logic [3:0] opAdi = 4'd4;
    localparam logic [3:0] opOri = 4'd5;
    localparam logic [3:0] opLhi = 4'd6;
    localparam logic [3:0] opLwd = 4'd7;
    localparam logic [3:0] opSwd = 4'd8;
    localparam logic [3:0] opJmp = 4'd9;
    localparam logic [3:0] opAlu = 4'd15;  // R-format, func picks the operation

    localparam logic [5:0] funcAdd = 6'd0;
    localparam logic [5:0] funcSub = 6'd1;
    localparam logic [5:0] funcAnd = 6'd2;
    localparam logic [5:0] funcOrr = 6'd3;
    localparam logic [5:0] funcWwd = 6'd28;
    localparam logic [5:0] funcHlt = 6'd29;

    // operand source selects from the hazard unit
    localparam logic [1:0] fwdReg   = 2'd0;
    localparam logic [1:0] fwdExMem = 2'd1;
    localparam logic [1:0] fwdMemWb = 2'd2;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluLhi} aluOpT;

    typedef struct packed {
        logic [3:0] opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [1:0] rd;
        logic [5:0] func;
    } rFmtT;

    typedef struct packed {
        logic [3:0] opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [7:0] imm;
    } iFmtT;

    typedef struct packed {
        logic [3:0]  opcode;
        logic [11:0] target;
    } jFmtT;

    typedef union packed {
        rFmtT rFmt;
        iFmtT iFmt;
        jFmtT jFmt;
    } instrU;

    typedef struct packed {
        logic                regWrite;
        logic                aluSrcImm;
        aluOpT               aluOp;
        logic                memRead;
        logic                memWrite;
        logic                memToReg;
        logic                isBranch;
        logic                branchOnEqual;
        logic                isJump;
        logic                isWwd;
        logic                isHalt;
        logic [1:0]          destIdx;
        logic [wordSize-1:0] imm;      // jump target for JMP
    } ctrlT;

    typedef struct packed {
        logic                valid;
        ctrlT                ctrl;
        logic [1:0]          rs;
        logic [1:0]          rt;
        logic [wordSize-1:0] pc;
        logic [wordSize-1:0] dataA;
        logic [wordSize-1:0] dataB;
    } idExT;

    typedef struct packed {
        logic                valid;
        ctrlT                ctrl;
        logic [wordSize-1:0] result;
        logic [wordSize-1:0] storeData;
    } exMemT;

    typedef struct packed {
        logic                valid;
        ctrlT                ctrl;
        logic [wordSize-1:0] result;  // load data already selected
    } memWbT;

endpackage

`default_nettype wire
